//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal
TOP       = tb_dcxplus_control
FILELIST  = tb.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "^Result: PASSED$$"

clean:
	rm -rf obj_dir

//--- control_pkg.sv
`default_nettype none

package control_pkg;

    ////////////////////////////////////////
    // widths with a meaning

    typedef logic [7:0]  apb_addr_t;
    typedef logic [31:0] apb_data_t;
    typedef logic [31:0] count_t;

    // status LED pin modes
    typedef enum logic [1:0] {
        led_status = 2'd0,
        mirror_opt = 2'd1,
        mirror_dc  = 2'd2,
        released   = 2'd3
    } reset_mode_t;

    ////////////////////////////////////////
    // bus and control bundles

    typedef struct packed {
        logic      psel;
        logic      penable;
        logic      pwrite;
        apb_addr_t paddr;
        apb_data_t pwdata;
    } apb_req_t;

    typedef struct packed {
        apb_data_t prdata;
        logic      pslverr;
    } apb_rsp_t;

    // raw inputs, lock and ready are asynchronous
    typedef struct packed {
        logic pll54_locked;
        logic pll_hdmi_locked;
        logic adv_ready;
        logic resync;
        logic force_generate;
    } link_status_t;

    typedef struct packed {
        logic pll54_locked;
        logic pll_hdmi_locked;
        logic adv_ready;
        logic resync;
        logic force_generate;
    } sync_status_t;

    typedef struct packed {
        logic oe;
        logic level;
    } led_pin_t;

    typedef struct packed {
        count_t pll54_losses;
        count_t pll_hdmi_losses;
        count_t resync_events;
    } fault_counts_t;

    typedef struct packed {
        logic        dc_request;
        logic        opt_request;
        reset_mode_t mode;
    } reset_control_t;

    ////////////////////////////////////////
    // register map

    localparam apb_addr_t reg_control         = 8'h00;
    localparam apb_addr_t reg_status          = 8'h04;
    localparam apb_addr_t reg_pll54_losses    = 8'h08;
    localparam apb_addr_t reg_pll_hdmi_losses = 8'h0C;
    localparam apb_addr_t reg_resync_events   = 8'h10;
    localparam apb_addr_t reg_clear           = 8'h14;

endpackage

`default_nettype wire

//--- control_regs.sv
`default_nettype none

module control_regs (
    input  wire                         control_clock,
    input  wire                         reset_dc,
    input  wire control_pkg::apb_req_t       apb_req,
    output control_pkg::apb_rsp_t       apb_rsp,
    input  wire control_pkg::sync_status_t   sync_status,
    input  wire                         dc_nreset,
    input  wire                         opt_nreset,
    input  wire control_pkg::fault_counts_t  fault_counts,
    output control_pkg::reset_control_t reset_control,
    output logic                        clear_counters
);

    import control_pkg::*;

    logic      access;
    logic      hit_control;
    logic      hit_status;
    logic      hit_pll54;
    logic      hit_pll_hdmi;
    logic      hit_resync;
    logic      hit_clear;
    logic      mapped;
    logic      read_only;
    logic      access_error;
    logic      write_ok;
    logic      read_ok;
    apb_data_t read_data;

    ////////////////////////////////////////
    // decode

    // access phase only, setup cycle does nothing
    assign access = apb_req.psel && apb_req.penable;

    assign hit_control  = apb_req.paddr == reg_control;
    assign hit_status   = apb_req.paddr == reg_status;
    assign hit_pll54    = apb_req.paddr == reg_pll54_losses;
    assign hit_pll_hdmi = apb_req.paddr == reg_pll_hdmi_losses;
    assign hit_resync   = apb_req.paddr == reg_resync_events;
    assign hit_clear    = apb_req.paddr == reg_clear;

    assign mapped = hit_control || hit_status || hit_pll54 || hit_pll_hdmi ||
                    hit_resync || hit_clear;
    assign read_only = hit_status || hit_pll54 || hit_pll_hdmi || hit_resync;

    assign access_error = !mapped || (apb_req.pwrite && read_only);
    assign write_ok     = access && apb_req.pwrite && !access_error;
    assign read_ok      = access && !apb_req.pwrite && !access_error;

    ////////////////////////////////////////
    // control register

    always_ff @(posedge control_clock) begin
        if (reset_dc) begin
            reset_control <= '{dc_request: 1'b0, opt_request: 1'b0, mode: led_status};
        end else if (write_ok && hit_control) begin
            reset_control <= '{
                dc_request:  apb_req.pwdata[0],
                opt_request: apb_req.pwdata[1],
                mode:        reset_mode_t'(apb_req.pwdata[3:2])
            };
        end
    end

    // counters clear on the edge that ends this cycle
    assign clear_counters = write_ok && hit_clear;

    ////////////////////////////////////////
    // read mux

    always_comb begin
        read_data = '0;
        if (hit_control) begin
            read_data[0]   = reset_control.dc_request;
            read_data[1]   = reset_control.opt_request;
            read_data[3:2] = reset_control.mode;
        end else if (hit_status) begin
            read_data[0] = sync_status.pll54_locked;
            read_data[1] = sync_status.pll_hdmi_locked;
            read_data[2] = sync_status.adv_ready;
            read_data[3] = sync_status.resync;
            read_data[4] = sync_status.force_generate;
            read_data[5] = dc_nreset;
            read_data[6] = opt_nreset;
        end else if (hit_pll54) begin
            read_data = fault_counts.pll54_losses;
        end else if (hit_pll_hdmi) begin
            read_data = fault_counts.pll_hdmi_losses;
        end else if (hit_resync) begin
            read_data = fault_counts.resync_events;
        end
    end

    // zero outside the access cycle
    assign apb_rsp.prdata  = read_ok ? read_data : '0;
    assign apb_rsp.pslverr = access && access_error;

endmodule

`default_nettype wire

//--- dcxplus_control.sv
`default_nettype none

module dcxplus_control #(
    parameter int unsigned hold_cycles   = 32_000_000,
    parameter int          slow_glow_bit = 26,
    parameter int          fast_glow_bit = 22,
    parameter int          blink_bit     = 24
) (
    input  wire                        control_clock,
    input  wire                        reset_dc,
    input  wire control_pkg::apb_req_t      apb_req,
    output control_pkg::apb_rsp_t      apb_rsp,
    input  wire control_pkg::link_status_t  link_status,
    output logic                       dc_nreset,
    output logic                       opt_nreset,
    output control_pkg::led_pin_t      status_led
);

    import control_pkg::*;

    reset_control_t reset_control;
    sync_status_t   sync_status;
    fault_counts_t  fault_counts;
    logic           clear_counters;
    logic           slow_glow_out;
    logic           fast_glow_out;

    ////////////////////////////////////////
    // register block and monitor

    control_regs regs (
        .control_clock  (control_clock),
        .reset_dc       (reset_dc),
        .apb_req        (apb_req),
        .apb_rsp        (apb_rsp),
        .sync_status    (sync_status),
        .dc_nreset      (dc_nreset),
        .opt_nreset     (opt_nreset),
        .fault_counts   (fault_counts),
        .reset_control  (reset_control),
        .clear_counters (clear_counters)
    );

    lock_monitor monitor (
        .control_clock  (control_clock),
        .reset_dc       (reset_dc),
        .link_status    (link_status),
        .clear_counters (clear_counters),
        .sync_status    (sync_status),
        .fault_counts   (fault_counts)
    );

    ////////////////////////////////////////
    // reset lines

    reset_hold_timer #(.hold_cycles(hold_cycles)) dc_hold (
        .control_clock (control_clock),
        .reset_dc      (reset_dc),
        .request       (reset_control.dc_request),
        .nreset        (dc_nreset)
    );

    // optical drive emulator
    reset_hold_timer #(.hold_cycles(hold_cycles)) opt_hold (
        .control_clock (control_clock),
        .reset_dc      (reset_dc),
        .request       (reset_control.opt_request),
        .nreset        (opt_nreset)
    );

    ////////////////////////////////////////
    // status led

    led_glow #(.glow_bit(slow_glow_bit)) slow_glow (
        .control_clock (control_clock),
        .reset_dc      (reset_dc),
        .glow          (slow_glow_out)
    );

    led_glow #(.glow_bit(fast_glow_bit)) fast_glow (
        .control_clock (control_clock),
        .reset_dc      (reset_dc),
        .glow          (fast_glow_out)
    );

    status_led_control #(.blink_bit(blink_bit)) led_control (
        .control_clock (control_clock),
        .reset_dc      (reset_dc),
        .reset_control (reset_control),
        .sync_status   (sync_status),
        .dc_nreset     (dc_nreset),
        .opt_nreset    (opt_nreset),
        .slow_glow     (slow_glow_out),
        .fast_glow     (fast_glow_out),
        .status_led    (status_led)
    );

endmodule

`default_nettype wire

//--- led_glow.sv
`default_nettype none

module led_glow #(
    parameter int glow_bit = 22
) (
    input  wire  control_clock,
    input  wire  reset_dc,
    output logic glow
);

    // ramp bits sit right below the top bit, pwm phase in the low bits
    localparam int ramp_width = glow_bit / 2;

    logic [glow_bit:0]     glow_count;
    logic [ramp_width-1:0] ramp;
    logic [ramp_width-1:0] pwm_phase;

    // top bit picks up or down slope, giving a triangle
    assign ramp = glow_count[glow_bit] ?
                  glow_count[glow_bit-1 -: ramp_width] :
                  ~glow_count[glow_bit-1 -: ramp_width];

    assign pwm_phase = glow_count[ramp_width-1:0];

    always_ff @(posedge control_clock) begin
        if (reset_dc) begin
            glow_count <= '0;
            glow       <= 1'b0;
        end else begin
            glow_count <= glow_count + 1'b1;
            glow       <= ramp > pwm_phase;
        end
    end

endmodule

`default_nettype wire

//--- lock_monitor.sv
`default_nettype none

module lock_monitor (
    input  wire                         control_clock,
    input  wire                         reset_dc,
    input  wire control_pkg::link_status_t   link_status,
    input  wire                         clear_counters,
    output control_pkg::sync_status_t   sync_status,
    output control_pkg::fault_counts_t  fault_counts
);

    import control_pkg::*;

    ////////////////////////////////////////
    // synchronizers

    // bit 0 pll54, bit 1 pll hdmi, bit 2 adv ready
    logic [2:0] async_in;
    logic [2:0] sync_meta;
    logic [2:0] sync_q;
    logic [1:0] sync_prev;
    logic [1:0] lock_fall;

    logic resync_q;
    logic resync_prev;
    logic resync_rise;
    logic force_q;

    assign async_in = {link_status.adv_ready, link_status.pll_hdmi_locked,
                       link_status.pll54_locked};

    always_ff @(posedge control_clock) begin
        if (reset_dc) begin
            sync_meta   <= '0;
            sync_q      <= '0;
            sync_prev   <= '0;
            resync_q    <= 1'b0;
            resync_prev <= 1'b0;
            resync_rise <= 1'b0;
            force_q     <= 1'b0;
        end else begin
            sync_meta   <= async_in;
            sync_q      <= sync_meta;
            sync_prev   <= sync_q[1:0];
            resync_q    <= link_status.resync;
            resync_prev <= resync_q;
            // delay the pulse to line up with the lock edges
            resync_rise <= resync_q && !resync_prev;
            force_q     <= link_status.force_generate;
        end
    end

    assign lock_fall = sync_prev & ~sync_q[1:0];

    assign sync_status = '{
        pll54_locked:    sync_q[0],
        pll_hdmi_locked: sync_q[1],
        adv_ready:       sync_q[2],
        resync:          resync_q,
        force_generate:  force_q
    };

    ////////////////////////////////////////
    // event counters

    always_ff @(posedge control_clock) begin
        if (reset_dc || clear_counters) begin
            fault_counts <= '0;
        end else begin
            if (lock_fall[0]) begin
                fault_counts.pll54_losses <= fault_counts.pll54_losses + 1'b1;
            end
            if (lock_fall[1]) begin
                fault_counts.pll_hdmi_losses <= fault_counts.pll_hdmi_losses + 1'b1;
            end
            if (resync_rise) begin
                fault_counts.resync_events <= fault_counts.resync_events + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- reset_hold_timer.sv
`default_nettype none

module reset_hold_timer #(
    parameter int unsigned hold_cycles = 32_000_000
) (
    input  wire  control_clock,
    input  wire  reset_dc,
    input  wire  request,
    output logic nreset
);

    import control_pkg::*;

    // nreset rises on the edge where the count reaches hold_cycles
    localparam count_t last_count = count_t'(hold_cycles - 1);

    count_t hold_count;

    always_ff @(posedge control_clock) begin
        if (reset_dc || request) begin
            hold_count <= '0;
            nreset     <= 1'b0;
        end else if (!nreset) begin
            hold_count <= hold_count + 1'b1;
            if (hold_count == last_count) begin
                nreset <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- status_led_control.sv
`default_nettype none

module status_led_control #(
    parameter int blink_bit = 24
) (
    input  wire                         control_clock,
    input  wire                         reset_dc,
    input  wire control_pkg::reset_control_t reset_control,
    input  wire control_pkg::sync_status_t   sync_status,
    input  wire                         dc_nreset,
    input  wire                         opt_nreset,
    input  wire                         slow_glow,
    input  wire                         fast_glow,
    output control_pkg::led_pin_t       status_led
);

    import control_pkg::*;

    logic [blink_bit:0] blink_count;
    led_pin_t           pin_next;

    always_comb begin
        pin_next = '{oe: 1'b1, level: 1'b1};
        case (reset_control.mode)
            led_status: begin
                if (!sync_status.pll_hdmi_locked) begin
                    pin_next.level = 1'b1;
                end else if (sync_status.resync) begin
                    pin_next.level = ~fast_glow;
                end else if (sync_status.force_generate) begin
                    // blink between glow and off
                    pin_next.level = blink_count[blink_bit] ? ~fast_glow : 1'b1;
                end else if (sync_status.adv_ready) begin
                    pin_next.level = 1'b0;
                end else begin
                    pin_next.level = ~slow_glow;
                end
            end
            // pull low only while the chosen line is held
            mirror_opt: begin
                pin_next.oe    = ~opt_nreset;
                pin_next.level = 1'b0;
            end
            mirror_dc: begin
                pin_next.oe    = ~dc_nreset;
                pin_next.level = 1'b0;
            end
            default: begin
                pin_next.oe    = 1'b0;
                pin_next.level = 1'b1;
            end
        endcase
    end

    always_ff @(posedge control_clock) begin
        if (reset_dc) begin
            blink_count <= '0;
            status_led  <= '{oe: 1'b1, level: 1'b1};
        end else begin
            blink_count <= blink_count + 1'b1;
            status_led  <= pin_next;
        end
    end

endmodule

`default_nettype wire

//--- tb.f
control_pkg.sv
reset_hold_timer.sv
led_glow.sv
status_led_control.sv
lock_monitor.sv
control_regs.sv
dcxplus_control.sv
tb_dcxplus_control.sv

//--- tb_dcxplus_control.sv
`default_nettype none

module tb_dcxplus_control;

    import control_pkg::*;

    localparam int          hold_cycles   = 40;
    localparam int          slow_glow_bit = 9;
    localparam int          fast_glow_bit = 6;
    localparam int          blink_bit     = 8;
    localparam int          clock_period  = 4;
    localparam logic [31:0] random_seed   = 32'h971b2d6a;

    // rough length of each test in cycles
    localparam int power_on_cycles = hold_cycles + 20;
    localparam int register_cycles = 40 * 8 + hold_cycles + 60;
    localparam int request_cycles  = 2 * (hold_cycles + 60);
    localparam int counting_cycles = 3 * 8 * 16 + 80;
    localparam int led_cycles      = 4 * hold_cycles + (1 << (fast_glow_bit + 2)) + 200;
    localparam int total_cycles    = power_on_cycles + register_cycles + request_cycles +
                                     counting_cycles + led_cycles;
    localparam int watchdog_time   = (2 * total_cycles + 1000) * clock_period;

    logic         control_clock = 1'b0;
    logic         reset_dc;
    apb_req_t     apb_req;
    apb_rsp_t     apb_rsp;
    link_status_t link_status;
    logic         dc_nreset;
    logic         opt_nreset;
    led_pin_t     status_led;

    int         error_count;
    int         check_count;
    logic [3:0] model_control;
    logic       model_dc_nreset;
    logic       model_opt_nreset;
    count_t     model_counts [3];
    logic       pin_watch;
    string      pin_case;

    dcxplus_control #(
        .hold_cycles   (hold_cycles),
        .slow_glow_bit (slow_glow_bit),
        .fast_glow_bit (fast_glow_bit),
        .blink_bit     (blink_bit)
    ) uut (
        .control_clock (control_clock),
        .reset_dc      (reset_dc),
        .apb_req       (apb_req),
        .apb_rsp       (apb_rsp),
        .link_status   (link_status),
        .dc_nreset     (dc_nreset),
        .opt_nreset    (opt_nreset),
        .status_led    (status_led)
    );

    always #(clock_period / 2) control_clock = ~control_clock;

    ////////////////////////////////////////
    // reference model

    // glow cases are not modelled here
    function automatic led_pin_t expected_pin(input reset_mode_t mode, input link_status_t link,
                                              input logic dc_n, input logic opt_n);
        led_pin_t pin;
        pin.oe    = 1'b1;
        pin.level = 1'b1;
        case (mode)
            led_status: begin
                if (link.pll_hdmi_locked && link.adv_ready) begin
                    pin.level = 1'b0;
                end
            end
            mirror_opt: begin
                pin.oe    = ~opt_n;
                pin.level = 1'b0;
            end
            mirror_dc: begin
                pin.oe    = ~dc_n;
                pin.level = 1'b0;
            end
            default: begin
                pin.oe = 1'b0;
            end
        endcase
        return pin;
    endfunction

    function automatic logic expected_error(input apb_addr_t addr, input logic write);
        case (addr)
            reg_control, reg_clear: return 1'b0;
            reg_status, reg_pll54_losses, reg_pll_hdmi_losses, reg_resync_events: return write;
            default: return 1'b1;
        endcase
    endfunction

    function automatic apb_data_t expected_read(input apb_addr_t addr);
        apb_data_t data;
        data = '0;
        case (addr)
            reg_control:         data[3:0] = model_control;
            reg_status:          data[6:0] = {model_opt_nreset, model_dc_nreset,
                                              link_status.force_generate, link_status.resync,
                                              link_status.adv_ready, link_status.pll_hdmi_locked,
                                              link_status.pll54_locked};
            reg_pll54_losses:    data = model_counts[0];
            reg_pll_hdmi_losses: data = model_counts[1];
            reg_resync_events:   data = model_counts[2];
            default:             data = '0;
        endcase
        return data;
    endfunction

    ////////////////////////////////////////
    // compare tasks

    task automatic check_data(input string name, input apb_data_t expected, input apb_data_t actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("ERROR %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic check_pin(input string name, input led_pin_t expected, input led_pin_t actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("ERROR %s: expected oe=%b level=%b, actual oe=%b level=%b",
                     name, expected.oe, expected.level, actual.oe, actual.level);
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("ERROR %s: expected %b, actual %b", name, expected, actual);
        end
    endtask

    // led pin against the model while the inputs are settled
    always @(negedge control_clock) begin
        if (pin_watch) begin
            check_pin(pin_case, expected_pin(reset_mode_t'(model_control[3:2]), link_status,
                      model_dc_nreset, model_opt_nreset), status_led);
        end
    end

    ////////////////////////////////////////
    // apb master, starts and ends on a falling edge

    task automatic apb_write(input apb_addr_t addr, input apb_data_t data, output logic err);
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = 1'b1;
        apb_req.paddr   = addr;
        apb_req.pwdata  = data;
        @(negedge control_clock);
        apb_req.penable = 1'b1;
        #1;
        err = apb_rsp.pslverr;
        @(negedge control_clock);
        apb_req = '0;
    endtask

    task automatic apb_read(input apb_addr_t addr, output apb_data_t data, output logic err);
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = 1'b0;
        apb_req.paddr   = addr;
        apb_req.pwdata  = '0;
        @(negedge control_clock);
        apb_req.penable = 1'b1;
        #1;
        data = apb_rsp.prdata;
        err  = apb_rsp.pslverr;
        @(negedge control_clock);
        apb_req = '0;
    endtask

    task automatic write_reg(input string name, input apb_addr_t addr, input apb_data_t data);
        logic err;
        logic exp_err;
        exp_err = expected_error(addr, 1'b1);
        apb_write(addr, data, err);
        check_bit({name, " pslverr"}, exp_err, err);
        if (!exp_err && addr == reg_control) begin
            model_control = data[3:0];
            if (data[0]) begin
                model_dc_nreset = 1'b0;
            end
            if (data[1]) begin
                model_opt_nreset = 1'b0;
            end
        end
        if (!exp_err && addr == reg_clear) begin
            foreach (model_counts[i]) begin
                model_counts[i] = '0;
            end
        end
    endtask

    task automatic read_reg(input string name, input apb_addr_t addr);
        apb_data_t data;
        logic      err;
        apb_read(addr, data, err);
        check_bit({name, " pslverr"}, expected_error(addr, 1'b0), err);
        check_data(name, expected_read(addr), data);
    endtask

    ////////////////////////////////////////
    // reset lines and stimulus helpers

    task automatic await_release(input string name, input logic dc_line);
        int   cycles;
        logic line;
        cycles = 0;
        line   = 1'b0;
        while (!line && cycles < hold_cycles + 8) begin
            @(negedge control_clock);
            cycles++;
            line = dc_line ? dc_nreset : opt_nreset;
        end
        check_count++;
        if (!line) begin
            error_count++;
            $display("%s: reset line still low after %0d cycles", name, cycles);
        end else if (cycles < hold_cycles || cycles > hold_cycles + 3) begin
            error_count++;
            $display("%s: reset line released after %0d cycles, allowed %0d to %0d",
                     name, cycles, hold_cycles, hold_cycles + 3);
        end
        if (dc_line) begin
            model_dc_nreset = 1'b1;
        end else begin
            model_opt_nreset = 1'b1;
        end
    endtask

    // request both so the release window starts at a known write
    task automatic release_lines(input string name);
        write_reg(name, reg_control, {28'd0, model_control[3:2], 2'b11});
        write_reg(name, reg_control, {28'd0, model_control[3:2], 2'b00});
        fork
            await_release({name, " dc"}, 1'b1);
            await_release({name, " opt"}, 1'b0);
        join
    endtask

    task automatic request_cycle(input string name, input logic dc_line);
        int hold_len;
        hold_len = 10 + $urandom % 30;
        write_reg(name, reg_control, dc_line ? 32'h1 : 32'h2);
        repeat (hold_len) begin
            @(negedge control_clock);
            check_bit({name, " held line"}, 1'b0, dc_line ? dc_nreset : opt_nreset);
            check_bit({name, " other line"}, 1'b1, dc_line ? opt_nreset : dc_nreset);
        end
        write_reg(name, reg_control, 32'h0);
        await_release(name, dc_line);
    endtask

    task automatic watch_pin(input string name, input int cycles);
        pin_case = name;
        repeat (6) @(negedge control_clock);
        pin_watch = 1'b1;
        repeat (cycles) @(negedge control_clock);
        pin_watch = 1'b0;
        @(negedge control_clock);
    endtask

    task automatic led_mirror(input string name, input reset_mode_t mode, input logic dc_line);
        write_reg(name, reg_control, {28'd0, mode, dc_line ? 2'b01 : 2'b10});
        watch_pin({name, " held"}, 16);
        write_reg(name, reg_control, {28'd0, mode, 2'b00});
        await_release(name, dc_line);
        watch_pin({name, " released"}, 16);
    endtask

    task automatic lock_losses(input logic hdmi, input int pulses);
        repeat (pulses) begin
            if (hdmi) begin
                link_status.pll_hdmi_locked = 1'b0;
            end else begin
                link_status.pll54_locked = 1'b0;
            end
            repeat (4) @(negedge control_clock);
            link_status.pll_hdmi_locked = 1'b1;
            link_status.pll54_locked    = 1'b1;
            repeat (6 + $urandom % 4) @(negedge control_clock);
        end
    endtask

    task automatic resync_pulses(input int pulses);
        repeat (pulses) begin
            link_status.resync = 1'b1;
            repeat (2) @(negedge control_clock);
            link_status.resync = 1'b0;
            repeat (6) @(negedge control_clock);
        end
    endtask

    ////////////////////////////////////////
    // test sequence

    initial begin
        int        pulses;
        apb_addr_t addr;
        logic      seen_high;
        logic      seen_low;
        void'($urandom(random_seed));
        reset_dc         = 1'b1;
        apb_req          = '0;
        link_status      = '{pll54_locked: 1'b1, pll_hdmi_locked: 1'b1, adv_ready: 1'b0,
                             resync: 1'b0, force_generate: 1'b0};
        error_count      = 0;
        check_count      = 0;
        model_control    = '0;
        model_dc_nreset  = 1'b0;
        model_opt_nreset = 1'b0;
        pin_watch        = 1'b0;
        pin_case         = "";
        foreach (model_counts[i]) begin
            model_counts[i] = '0;
        end
        repeat (8) @(negedge control_clock);
        reset_dc = 1'b0;

        // power-on hold
        check_bit("dc after reset", 1'b0, dc_nreset);
        check_bit("opt after reset", 1'b0, opt_nreset);
        check_pin("led after reset", '{oe: 1'b1, level: 1'b1}, status_led);
        fork
            await_release("power-on dc", 1'b1);
            await_release("power-on opt", 1'b0);
        join
        read_reg("control after reset", reg_control);

        // register access
        read_reg("status idle", reg_status);
        for (int i = 0; i < 8; i++) begin
            write_reg("control write", reg_control, $urandom);
            read_reg("control readback", reg_control);
        end
        for (int i = 0; i < 4; i++) begin
            do begin
                addr = apb_addr_t'($urandom);
            end while (!expected_error(addr, 1'b0));
            read_reg("unmapped read", addr);
            write_reg("unmapped write", addr, $urandom);
            read_reg("control kept", reg_control);
        end
        write_reg("status write", reg_status, $urandom);
        write_reg("counter write", reg_resync_events, $urandom);
        read_reg("control kept", reg_control);
        release_lines("register release");
        read_reg("status released", reg_status);

        // reset requests
        request_cycle("dc request", 1'b1);
        request_cycle("opt request", 1'b0);

        // event counting
        pulses = 1 + $urandom % 8;
        model_counts[0] = pulses;
        lock_losses(1'b0, pulses);
        pulses = 1 + $urandom % 8;
        model_counts[1] = pulses;
        lock_losses(1'b1, pulses);
        pulses = 1 + $urandom % 8;
        model_counts[2] = pulses;
        resync_pulses(pulses);
        repeat (8) @(negedge control_clock);
        read_reg("pll54 losses", reg_pll54_losses);
        read_reg("pll hdmi losses", reg_pll_hdmi_losses);
        read_reg("resync events", reg_resync_events);
        write_reg("clear counters", reg_clear, $urandom);
        read_reg("pll54 cleared", reg_pll54_losses);
        read_reg("pll hdmi cleared", reg_pll_hdmi_losses);
        read_reg("resync cleared", reg_resync_events);
        read_reg("clear reads zero", reg_clear);

        // led modes, counters are not read after this point
        write_reg("led status mode", reg_control, 32'h0);
        link_status.pll_hdmi_locked = 1'b0;
        watch_pin("hdmi pll unlocked", 20);
        link_status.pll_hdmi_locked = 1'b1;
        link_status.adv_ready       = 1'b1;
        watch_pin("adv ready", 20);
        link_status.adv_ready = 1'b0;
        led_mirror("mirror dc", mirror_dc, 1'b1);
        led_mirror("mirror opt", mirror_opt, 1'b0);
        write_reg("released mode", reg_control, {28'd0, released, 2'b00});
        watch_pin("released", 20);

        // resync glow must toggle the level
        write_reg("glow mode", reg_control, 32'h0);
        link_status.resync = 1'b1;
        seen_high = 1'b0;
        seen_low  = 1'b0;
        repeat (6) @(negedge control_clock);
        for (int i = 0; i < (1 << (fast_glow_bit + 2)); i++) begin
            @(negedge control_clock);
            check_bit("resync glow oe", 1'b1, status_led.oe);
            if (status_led.level) begin
                seen_high = 1'b1;
            end else begin
                seen_low = 1'b1;
            end
        end
        check_count++;
        if (!(seen_high && seen_low)) begin
            error_count++;
            $display("resync glow: led level did not toggle within %0d cycles",
                     1 << (fast_glow_bit + 2));
        end
        link_status.resync = 1'b0;
        repeat (4) @(negedge control_clock);

        $display("checks %0d, errors %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    initial begin
        #(watchdog_time);
        $display("watchdog expired after %0d time units, the test did not finish", watchdog_time);
        $display("Result: FAILED");
        $finish;
    end

endmodule

`default_nettype wire
